//--- design/mipsCore_defines.svh
`ifndef MIPSCORE_DEFINES_SVH
`define MIPSCORE_DEFINES_SVH

// First fetch address out of reset
`define RESET_PC        32'h00400000

// Primary opcodes
`define OPCODE_RTYPE    6'h00
`define OPCODE_J        6'h02
`define OPCODE_BEQ      6'h04
`define OPCODE_BNE      6'h05
`define OPCODE_ADDI     6'h08
`define OPCODE_ADDIU    6'h09
`define OPCODE_SLTI     6'h0a
`define OPCODE_SLTIU    6'h0b
`define OPCODE_ANDI     6'h0c
`define OPCODE_ORI      6'h0d
`define OPCODE_LUI      6'h0f
`define OPCODE_LW       6'h23
`define OPCODE_SW       6'h2b

// R-type function codes
`define FUNCT_ADD       6'h20
`define FUNCT_ADDU      6'h21
`define FUNCT_SUB       6'h22
`define FUNCT_SUBU      6'h23
`define FUNCT_AND       6'h24
`define FUNCT_OR        6'h25
`define FUNCT_XOR       6'h26
`define FUNCT_NOR       6'h27
`define FUNCT_SLT       6'h2a

// Instruction field positions
`define OP_FIELD        31:26
`define RS_FIELD        25:21
`define RT_FIELD        20:16
`define RD_FIELD        15:11
`define IMM_FIELD       15:0
`define IMM_SIGN        15
`define FUNCT_FIELD     5:0
`define JADDR_FIELD     25:0

`define ZERO_REG        5'd0

`endif

//--- design/mipsPkg.sv
package mipsPkg;

    // Data, address and instruction word
    typedef logic [31:0] word_t;

    // Register file index
    typedef logic [4:0] regId_t;

    // Operations the execute stage can ask for
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_LT,
        ALU_LUI
    } aluCtrl_t;

    // Where an execute operand comes from
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EXMEM,
        FWD_MEMWB
    } fwdSel_t;

endpackage

//--- design/decodeUnit.sv
`timescale 1ns/100ps
`include "mipsCore_defines.svh"

module decodeUnit import mipsPkg::*; (
    input  word_t    instr,
    output logic     regDst,
    output logic     regWrite,
    output logic     aluSrc,
    output logic     memRead,
    output logic     memWrite,
    output logic     memToReg,
    output logic     branch,
    output logic     branchEq,
    output logic     jump,
    output aluCtrl_t aluCtrl,
    output logic     aluSigned,
    output logic     zeroExtImm
);

    // Set by every ALU-immediate opcode
    logic immAlu;

    always_comb begin
        regDst     = 1'b0;
        regWrite   = 1'b0;
        aluSrc     = 1'b0;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        memToReg   = 1'b0;
        branch     = 1'b0;
        branchEq   = 1'b0;
        jump       = 1'b0;
        aluCtrl    = ALU_ADD;
        aluSigned  = 1'b0;
        zeroExtImm = 1'b0;
        immAlu     = 1'b0;
        case (instr[`OP_FIELD])
            `OPCODE_RTYPE: begin
                regDst   = 1'b1;
                regWrite = 1'b1;
                case (instr[`FUNCT_FIELD])
                    `FUNCT_ADD, `FUNCT_ADDU: aluCtrl = ALU_ADD;
                    `FUNCT_SUB, `FUNCT_SUBU: aluCtrl = ALU_SUB;
                    `FUNCT_AND:              aluCtrl = ALU_AND;
                    `FUNCT_OR:               aluCtrl = ALU_OR;
                    `FUNCT_XOR:              aluCtrl = ALU_XOR;
                    `FUNCT_NOR:              aluCtrl = ALU_NOR;
                    `FUNCT_SLT: begin
                        aluCtrl   = ALU_LT;
                        aluSigned = 1'b1;
                    end
                    // unsupported function codes retire as no-ops
                    default:                 regWrite = 1'b0;
                endcase
            end
            `OPCODE_ADDI, `OPCODE_ADDIU: begin
                immAlu = 1'b1;
            end
            `OPCODE_SLTI: begin
                immAlu    = 1'b1;
                aluCtrl   = ALU_LT;
                aluSigned = 1'b1;
            end
            // Immediate is still sign extended, compare is unsigned
            `OPCODE_SLTIU: begin
                immAlu  = 1'b1;
                aluCtrl = ALU_LT;
            end
            `OPCODE_ANDI: begin
                immAlu     = 1'b1;
                aluCtrl    = ALU_AND;
                zeroExtImm = 1'b1;
            end
            `OPCODE_ORI: begin
                immAlu     = 1'b1;
                aluCtrl    = ALU_OR;
                zeroExtImm = 1'b1;
            end
            `OPCODE_LUI: begin
                immAlu  = 1'b1;
                aluCtrl = ALU_LUI;
            end
            `OPCODE_LW: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                memRead  = 1'b1;
                memToReg = 1'b1;
            end
            `OPCODE_SW: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
            end
            `OPCODE_BEQ, `OPCODE_BNE: begin
                branch   = 1'b1;
                branchEq = (instr[`OP_FIELD] == `OPCODE_BEQ);
                aluCtrl  = ALU_SUB;
            end
            `OPCODE_J: begin
                jump = 1'b1;
            end
            default: ;
        endcase
        if (immAlu) begin
            aluSrc   = 1'b1;
            regWrite = 1'b1;
        end
    end

endmodule

//--- design/regFile.sv
`timescale 1ns/100ps

module regFile import mipsPkg::*; (
    input  logic   iClk,
    input  logic   iRst_n,
    input  regId_t rdId0,
    input  regId_t rdId1,
    output word_t  rdData0,
    output word_t  rdData1,
    input  regId_t wrId,
    input  word_t  wrData,
    input  logic   wrEn
);

    word_t regs [32];
    logic  wrValid;

    // Register zero is never written, so it keeps its reset value
    assign wrValid = wrEn && (wrId != 5'd0);

    always_ff @(posedge iClk or negedge iRst_n) begin
        if (!iRst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrValid) begin
            regs[wrId] <= wrData;
        end
    end

    // Writeback in the same cycle reaches decode directly
    assign rdData0 = (wrValid && (wrId == rdId0)) ? wrData : regs[rdId0];
    assign rdData1 = (wrValid && (wrId == rdId1)) ? wrData : regs[rdId1];

endmodule

//--- design/aluUnit.sv
`timescale 1ns/100ps

module aluUnit import mipsPkg::*; (
    input  word_t    a,
    input  word_t    b,
    input  aluCtrl_t aluCtrl,
    input  logic     aluSigned,
    output word_t    result,
    output logic     zero
);

    logic lessThan;

    // SLT and SLTI compare signed, SLTIU unsigned
    assign lessThan = aluSigned ? ($signed(a) < $signed(b)) : (a < b);

    always_comb begin
        case (aluCtrl)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_NOR: result = ~(a | b);
            ALU_LT:  result = {31'd0, lessThan};
            // Upper half from the immediate, lower half cleared
            ALU_LUI: result = {b[15:0], 16'd0};
            default: result = '0;
        endcase
    end

    // Branch compare runs as a subtract
    assign zero = (result == '0);

endmodule

//--- design/hazardUnit.sv
`timescale 1ns/100ps
`include "mipsCore_defines.svh"

module hazardUnit import mipsPkg::*; (
    input  regId_t  exRs,
    input  regId_t  exRt,
    input  regId_t  memRd,
    input  regId_t  wbRd,
    input  logic    memRegWrite,
    input  logic    wbRegWrite,
    input  logic    exMemRead,
    input  regId_t  idRs,
    input  regId_t  idRt,
    input  logic    branchTaken,
    input  logic    idJump,
    output fwdSel_t fwdA,
    output fwdSel_t fwdB,
    output logic    stall,
    output logic    flushFetch,
    output logic    flushDecode
);

    logic loadUse;

    // Younger result in EX/MEM wins over MEM/WB
    function automatic fwdSel_t pickSource(regId_t src);
        if (memRegWrite && (memRd != `ZERO_REG) && (memRd == src)) begin
            return FWD_EXMEM;
        end
        if (wbRegWrite && (wbRd != `ZERO_REG) && (wbRd == src)) begin
            return FWD_MEMWB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        fwdA = pickSource(exRs);
        fwdB = pickSource(exRt);
    end

    // Load in execute, its target read by the instruction in decode
    assign loadUse = exMemRead && (exRt != `ZERO_REG) &&
                     ((exRt == idRs) || (exRt == idRt));

    always_comb begin
        stall       = 1'b0;
        flushFetch  = 1'b0;
        flushDecode = 1'b0;
        if (branchTaken) begin
            flushFetch  = 1'b1;
            flushDecode = 1'b1;
        end else if (idJump) begin
            flushFetch = 1'b1;
        end else if (loadUse) begin
            stall = 1'b1;
        end
    end

endmodule

//--- design/mipsCore.sv
`timescale 1ns/100ps
`include "mipsCore_defines.svh"

module mipsCore import mipsPkg::*; (
    input  logic  iClk,
    input  logic  iRst_n,
    output word_t oInstAddr,
    input  word_t iInstr,
    output word_t oMemAddr,
    output logic  oMemRead,
    output logic  oMemWrite,
    output word_t oWrData,
    input  word_t iRdData
);

    // Fetch and IF/ID
    word_t    pc, fetchAddr, fetchPlus4;
    word_t    ifidInstr, ifidPlus4;
    // Decode
    regId_t   idRs, idRt;
    word_t    idRdData0, idRdData1, idImm, idJumpTarget;
    logic     idRegDst, idRegWrite, idAluSrc, idMemRead, idMemWrite, idMemToReg;
    logic     idBranch, idBranchEq, idJump, idAluSigned, idZeroExt;
    aluCtrl_t idAluCtrl;
    // ID/EX and execute
    logic     exRegDst, exRegWrite, exAluSrc, exMemRead, exMemWrite, exMemToReg;
    logic     exBranch, exBranchEq, exJump, exAluSigned, exZero, branchTaken;
    aluCtrl_t exAluCtrl;
    regId_t   exRs, exRt, exRd, exWrId;
    word_t    exData0, exData1, exImm, exPlus4, exJumpTarget;
    word_t    exOpA, exOpB, exAluB, exAluOut, exBranchTarget;
    fwdSel_t  fwdA, fwdB;
    logic     stall, flushFetch, flushDecode;
    // EX/MEM, MEM/WB
    logic     memRegWrite, memMemRead, memMemWrite, memMemToReg, wbRegWrite;
    regId_t   memRd, wbRd;
    word_t    memAluOut, memStoreData, memWbData, wbData;

    function automatic word_t fwdMux(fwdSel_t sel, word_t regVal);
        case (sel)
            FWD_EXMEM: return memAluOut;
            FWD_MEMWB: return wbData;
            default:   return regVal;
        endcase
    endfunction

    // A jump sitting in ID/EX redirects this fetch
    assign fetchAddr  = exJump ? exJumpTarget : pc;
    assign fetchPlus4 = fetchAddr + 32'd4;
    assign oInstAddr  = fetchAddr;

    always_ff @(posedge iClk or negedge iRst_n) begin
        if (!iRst_n) begin
            pc        <= `RESET_PC;
            ifidInstr <= '0;
        end else begin
            if (branchTaken) begin
                pc <= exBranchTarget;
            end else if (!stall && !flushFetch) begin
                pc <= fetchPlus4;
            end
            if (flushFetch) begin
                ifidInstr <= '0;
            end else if (!stall) begin
                ifidInstr <= iInstr;
            end
        end
    end

    always_ff @(posedge iClk) begin
        if (!stall) begin
            ifidPlus4 <= fetchPlus4;
        end
    end

    assign idRs = ifidInstr[`RS_FIELD];
    assign idRt = ifidInstr[`RT_FIELD];
    assign idImm = idZeroExt ? {16'd0, ifidInstr[`IMM_FIELD]} :
                   {{16{ifidInstr[`IMM_SIGN]}}, ifidInstr[`IMM_FIELD]};
    assign idJumpTarget = {ifidPlus4[31:28], ifidInstr[`JADDR_FIELD], 2'b00};

    decodeUnit uDecode (
        .instr(ifidInstr), .regDst(idRegDst), .regWrite(idRegWrite), .aluSrc(idAluSrc),
        .memRead(idMemRead), .memWrite(idMemWrite), .memToReg(idMemToReg),
        .branch(idBranch), .branchEq(idBranchEq), .jump(idJump), .aluCtrl(idAluCtrl),
        .aluSigned(idAluSigned), .zeroExtImm(idZeroExt)
    );

    regFile uRegFile (
        .iClk(iClk), .iRst_n(iRst_n), .rdId0(idRs), .rdId1(idRt),
        .rdData0(idRdData0), .rdData1(idRdData1),
        .wrId(wbRd), .wrData(wbData), .wrEn(wbRegWrite)
    );

    // A stall or flush leaves a bubble in the ID/EX control
    always_ff @(posedge iClk or negedge iRst_n) begin
        if (!iRst_n) begin
            {exRegDst, exRegWrite, exAluSrc, exMemRead, exMemWrite} <= '0;
            {exMemToReg, exBranch, exBranchEq, exJump, exAluSigned} <= '0;
            exAluCtrl <= ALU_ADD;
        end else if (stall || flushDecode) begin
            {exRegDst, exRegWrite, exAluSrc, exMemRead, exMemWrite} <= '0;
            {exMemToReg, exBranch, exBranchEq, exJump, exAluSigned} <= '0;
            exAluCtrl <= ALU_ADD;
        end else begin
            {exRegDst, exRegWrite, exAluSrc} <= {idRegDst, idRegWrite, idAluSrc};
            {exMemRead, exMemWrite, exMemToReg} <= {idMemRead, idMemWrite, idMemToReg};
            {exBranch, exBranchEq, exJump} <= {idBranch, idBranchEq, idJump};
            exAluSigned <= idAluSigned;
            exAluCtrl   <= idAluCtrl;
        end
    end

    always_ff @(posedge iClk) begin
        exRs         <= idRs;
        exRt         <= idRt;
        exRd         <= ifidInstr[`RD_FIELD];
        exData0      <= idRdData0;
        exData1      <= idRdData1;
        exImm        <= idImm;
        exPlus4      <= ifidPlus4;
        exJumpTarget <= idJumpTarget;
    end

    hazardUnit uHazard (
        .exRs(exRs), .exRt(exRt), .memRd(memRd), .wbRd(wbRd),
        .memRegWrite(memRegWrite), .wbRegWrite(wbRegWrite), .exMemRead(exMemRead),
        .idRs(idRs), .idRt(idRt), .branchTaken(branchTaken), .idJump(idJump),
        .fwdA(fwdA), .fwdB(fwdB), .stall(stall),
        .flushFetch(flushFetch), .flushDecode(flushDecode)
    );

    always_comb begin
        exOpA = fwdMux(fwdA, exData0);
        exOpB = fwdMux(fwdB, exData1);
    end

    assign exAluB = exAluSrc ? exImm : exOpB;
    assign exWrId = exRegDst ? exRd : exRt;
    assign exBranchTarget = exPlus4 + {exImm[29:0], 2'b00};
    // BEQ wants zero, BNE wants nonzero
    assign branchTaken = exBranch && (exZero == exBranchEq);

    aluUnit uAlu (
        .a(exOpA), .b(exAluB), .aluCtrl(exAluCtrl), .aluSigned(exAluSigned),
        .result(exAluOut), .zero(exZero)
    );

    always_ff @(posedge iClk or negedge iRst_n) begin
        if (!iRst_n) begin
            {memRegWrite, memMemRead, memMemWrite, memMemToReg, wbRegWrite} <= '0;
        end else begin
            {memRegWrite, memMemRead} <= {exRegWrite, exMemRead};
            {memMemWrite, memMemToReg} <= {exMemWrite, exMemToReg};
            wbRegWrite <= memRegWrite;
        end
    end

    always_ff @(posedge iClk) begin
        memRd        <= exWrId;
        memAluOut    <= exAluOut;
        memStoreData <= exOpB;
        wbRd         <= memRd;
        wbData       <= memWbData;
    end

    assign memWbData = memMemToReg ? iRdData : memAluOut;
    assign oMemAddr  = memAluOut;
    assign oWrData   = memStoreData;
    assign oMemRead  = memMemRead;
    assign oMemWrite = memMemWrite;

endmodule

//--- bench/mipsCore_chk.sv
`timescale 1ns/100ps

module mipsCore_chk import mipsPkg::*; (
    input logic  iClk,
    input logic  iRst_n,
    input word_t oInstAddr,
    input logic  oMemRead,
    input logic  oMemWrite
);

    int failCount = 0;

    // A memory-stage instruction is a load or a store, never both
    strobesExclusive: assert property (
        @(posedge iClk) disable iff (!iRst_n) !(oMemRead && oMemWrite)
    ) else begin
        $error("oMemRead and oMemWrite high together");
        failCount++;
    end

    // Stage registers still hold no-ops right after release
    quietAfterReset: assert property (
        @(posedge iClk) $rose(iRst_n) |-> (!oMemRead && !oMemWrite)
    ) else begin
        $error("memory strobe active in the first cycle after reset");
        failCount++;
    end

    fetchAligned: assert property (
        @(posedge iClk) disable iff (!iRst_n) (oInstAddr[1:0] == 2'b00)
    ) else begin
        $error("oInstAddr %h is not word aligned", oInstAddr);
        failCount++;
    end

endmodule

bind mipsCore mipsCore_chk uChk (.*);

//--- bench/tbMipsCore.sv
`timescale 1ns/100ps
`include "mipsCore_defines.svh"

module tbMipsCore import mipsPkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int STORE_BOUND  = 24;
    localparam int TOTAL_STORES = 24;
    localparam int TOTAL_LOADS  = 1;
    localparam int WATCHDOG_CYC = (TOTAL_STORES + TOTAL_LOADS) * STORE_BOUND + 100;

    logic  iClk, iRst_n, oMemRead, oMemWrite;
    word_t oInstAddr, iInstr, oMemAddr, oWrData, iRdData, instOffset;
    word_t imem [64];
    word_t dmem [64];
    int    progLen, errors, checks, seed;

    mipsCore UUT (.*);

    // Instruction ROM returns a NOP outside the program window
    assign instOffset = oInstAddr - `RESET_PC;
    assign iInstr  = (instOffset < 256) ? imem[instOffset[7:2]] : 32'h0;
    assign iRdData = dmem[oMemAddr[7:2]];

    always @(posedge iClk) begin
        if (oMemWrite) begin
            dmem[oMemAddr[7:2]] <= oWrData;
        end
    end

    initial begin
        iClk = 1'b0;
        forever #(CLK_PERIOD / 2) iClk = ~iClk;
    end

    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("Watchdog expired at %0t, the run did not finish", $time);
        $display("tests failed");
        $finish;
    end

    function automatic word_t rType(logic [5:0] funct, regId_t rd, regId_t rs, regId_t rt);
        return {`OPCODE_RTYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic word_t iType(logic [5:0] op, regId_t rt, regId_t rs, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jType(int slot);
        word_t target;
        target = `RESET_PC + slot * 4;
        return {`OPCODE_J, target[27:2]};
    endfunction

    function automatic word_t signExt16(logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    // Reference results per MIPS32 R-type definitions
    function automatic word_t rTypeResult(logic [5:0] funct, word_t a, word_t b);
        case (funct)
            `FUNCT_ADD, `FUNCT_ADDU: return a + b;
            `FUNCT_SUB, `FUNCT_SUBU: return a - b;
            `FUNCT_AND: return a & b;
            `FUNCT_OR:  return a | b;
            `FUNCT_XOR: return a ^ b;
            `FUNCT_NOR: return ~(a | b);
            `FUNCT_SLT: return {31'd0, $signed(a) < $signed(b)};
            default:    return 32'h0;
        endcase
    endfunction

    task automatic emit(word_t w);
        imem[progLen] = w;
        progLen++;
    endtask

    task automatic loadConst(regId_t r, word_t v);
        emit(iType(`OPCODE_LUI, r, `ZERO_REG, v[31:16]));
        emit(iType(`OPCODE_ORI, r, r, v[15:0]));
    endtask

    task automatic storeWord(regId_t rt, logic [15:0] addr);
        emit(iType(`OPCODE_SW, rt, `ZERO_REG, addr));
    endtask

    // Core held in reset while the next program is loaded
    task automatic holdReset();
        @(posedge iClk);
        #1 iRst_n = 1'b0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = 32'h0;
        end
        progLen = 0;
    endtask

    task automatic releaseReset();
        repeat (2) @(posedge iClk);
        #1;
        checks++;
        if (oInstAddr !== `RESET_PC) begin
            $display("FAILED %0t oInstAddr expected %h got %h", $time, `RESET_PC, oInstAddr);
            errors++;
        end
        iRst_n = 1'b1;
    endtask

    // Next load or store strobe, sampled mid-cycle
    task automatic waitStrobe(bit wantLoad, output bit seen);
        int waited;
        waited = 0;
        seen   = 0;
        while (!seen && waited < STORE_BOUND) begin
            @(negedge iClk);
            waited++;
            seen = wantLoad ? oMemRead : oMemWrite;
        end
    endtask

    task automatic expectStore(word_t expAddr, word_t expData);
        bit seen;
        waitStrobe(1'b0, seen);
        checks++;
        if (!seen) begin
            $display("%0t: no store within %0d cycles, expected %h at address %h",
                     $time, STORE_BOUND, expData, expAddr);
            errors++;
        end else begin
            if (oMemAddr !== expAddr) begin
                $display("FAILED %0t oMemAddr expected %h got %h", $time, expAddr, oMemAddr);
                errors++;
            end
            if (oWrData !== expData) begin
                $display("FAILED %0t oWrData expected %h got %h", $time, expData, oWrData);
                errors++;
            end
        end
    endtask

    task automatic expectLoad(word_t expAddr);
        bit seen;
        waitStrobe(1'b1, seen);
        checks++;
        if (!seen) begin
            $display("%0t: no load within %0d cycles, expected one at address %h",
                     $time, STORE_BOUND, expAddr);
            errors++;
        end else if (oMemAddr !== expAddr) begin
            $display("FAILED %0t oMemAddr expected %h got %h", $time, expAddr, oMemAddr);
            errors++;
        end
    endtask

    task automatic testAluOps();
        logic [5:0] functs [9];
        word_t      a, b;
        functs = '{`FUNCT_ADD, `FUNCT_ADDU, `FUNCT_SUB, `FUNCT_SUBU, `FUNCT_AND,
                   `FUNCT_OR, `FUNCT_XOR, `FUNCT_NOR, `FUNCT_SLT};
        // Two bits of headroom so ADD and SUB cannot overflow
        a = $random(seed) >>> 2;
        b = $random(seed) >>> 2;
        if (a[31] == b[31]) begin
            b = -b;
        end
        holdReset();
        loadConst(5'd1, a);
        loadConst(5'd2, b);
        for (int i = 0; i < 9; i++) begin
            emit(rType(functs[i], 5'd3, 5'd1, 5'd2));
            storeWord(5'd3, 16'(i * 4));
        end
        emit(rType(`FUNCT_SLT, 5'd3, 5'd2, 5'd1));
        storeWord(5'd3, 16'd36);
        releaseReset();
        for (int i = 0; i < 9; i++) begin
            expectStore(word_t'(i * 4), rTypeResult(functs[i], a, b));
        end
        expectStore(32'd36, rTypeResult(`FUNCT_SLT, b, a));
    endtask

    task automatic testForwarding();
        word_t x;
        x = $random(seed);
        holdReset();
        loadConst(5'd1, x);
        emit(rType(`FUNCT_ADDU, 5'd2, 5'd1, 5'd1));
        emit(rType(`FUNCT_ADDU, 5'd3, 5'd2, 5'd1));
        // Result aimed at r0 must not reach the next two instructions
        emit(rType(`FUNCT_ADDU, 5'd0, 5'd1, 5'd1));
        emit(rType(`FUNCT_ADDU, 5'd4, 5'd0, 5'd3));
        emit(rType(`FUNCT_ADDU, 5'd5, 5'd0, 5'd4));
        storeWord(5'd2, 16'h40);
        storeWord(5'd3, 16'h44);
        storeWord(5'd4, 16'h48);
        storeWord(5'd5, 16'h4c);
        releaseReset();
        expectStore(32'h40, x + x);
        expectStore(32'h44, x + x + x);
        expectStore(32'h48, x + x + x);
        expectStore(32'h4c, x + x + x);
    endtask

    task automatic testLoadUse();
        word_t       v;
        logic [15:0] imm;
        v   = $random(seed);
        imm = $random(seed);
        holdReset();
        dmem[32] = v;
        emit(iType(`OPCODE_LW, 5'd5, `ZERO_REG, 16'h80));
        emit(iType(`OPCODE_ADDIU, 5'd6, 5'd5, imm));
        storeWord(5'd6, 16'h84);
        storeWord(5'd5, 16'h88);
        releaseReset();
        expectLoad(32'h80);
        expectStore(32'h84, v + signExt16(imm));
        expectStore(32'h88, v);
    endtask

    task automatic testBranches();
        logic [15:0] p, q;
        p = {1'b0, 15'($random(seed))};
        q = p ^ 16'h0001;
        holdReset();
        emit(iType(`OPCODE_ADDIU, 5'd1, `ZERO_REG, p));
        emit(iType(`OPCODE_ADDIU, 5'd2, `ZERO_REG, p));
        emit(iType(`OPCODE_ADDIU, 5'd3, `ZERO_REG, q));
        emit(iType(`OPCODE_BEQ, 5'd2, 5'd1, 16'd2));
        storeWord(5'd1, 16'h00);
        storeWord(5'd2, 16'h04);
        storeWord(5'd3, 16'h08);
        emit(iType(`OPCODE_BNE, 5'd2, 5'd1, 16'd1));
        storeWord(5'd1, 16'h0c);
        emit(iType(`OPCODE_BNE, 5'd3, 5'd1, 16'd1));
        storeWord(5'd2, 16'h10);
        storeWord(5'd3, 16'h14);
        releaseReset();
        expectStore(32'h08, {16'd0, q});
        expectStore(32'h0c, {16'd0, p});
        expectStore(32'h14, {16'd0, q});
    endtask

    task automatic testJumpImm();
        word_t       r, sa, sb;
        logic [15:0] immA, immB;
        r    = $random(seed);
        immA = {1'b0, r[14:0]};
        immB = {1'b1, r[30:16]};
        sa   = signExt16(immA);
        sb   = signExt16(immB);
        holdReset();
        emit(iType(`OPCODE_ADDIU, 5'd1, `ZERO_REG, immA));
        emit(jType(3));
        storeWord(5'd1, 16'h00);
        storeWord(5'd1, 16'h04);
        emit(iType(`OPCODE_ADDI, 5'd2, 5'd1, immB));
        emit(iType(`OPCODE_SLTI, 5'd3, 5'd1, immB));
        emit(iType(`OPCODE_SLTIU, 5'd4, 5'd1, immB));
        emit(iType(`OPCODE_ANDI, 5'd5, 5'd1, immB));
        storeWord(5'd2, 16'h08);
        storeWord(5'd3, 16'h0c);
        storeWord(5'd4, 16'h10);
        storeWord(5'd5, 16'h14);
        releaseReset();
        expectStore(32'h04, sa);
        expectStore(32'h08, sa + sb);
        expectStore(32'h0c, {31'd0, $signed(sa) < $signed(sb)});
        expectStore(32'h10, {31'd0, sa < sb});
        expectStore(32'h14, sa & {16'd0, immB});
    endtask

    initial begin
        iRst_n  = 1'b0;
        errors  = 0;
        checks  = 0;
        progLen = 0;
        seed    = 45296;
        for (int i = 0; i < 64; i++) begin
            imem[i] = 32'h0;
            dmem[i] = 32'hda7a0000 + word_t'(i * 4);
        end
        testAluOps();
        testForwarding();
        testLoadUse();
        testBranches();
        testJumpImm();
        $display("Summary: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, UUT.uChk.failCount);
        if (errors == 0 && UUT.uChk.failCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+design
design/mipsPkg.sv
design/decodeUnit.sv
design/regFile.sv
design/aluUnit.sv
design/hazardUnit.sv
design/mipsCore.sv
bench/mipsCore_chk.sv
bench/tbMipsCore.sv
